// ==== build.f ====
+incdir+source
source/cache_pkg.sv
source/mem_pkg.sv
source/cache_array.sv
source/cache_ctrl.sv
source/bank_dispatch.sv
source/mem_bank.sv
source/bank_merge.sv
source/mem_system.sv
dv/mem_system_checker.sv
dv/tb_mem_system.sv

// ==== dv/mem_system_checker.sv ====
// Samples at the falling edge when all DUT outputs are settled; the model only knows words the CPU wrote
`timescale 1ns/10ps
`include "mem_system_defines.svh"

module mem_system_checker
   import cache_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  req_valid,
   input  cpu_op_t               req_op,
   input  logic [`MS_ADDR_W-1:0] req_addr,
   input  logic [`MS_DATA_W-1:0] req_wdata,
   input  logic                  req_ready,
   input  logic                  resp_valid,
   input  logic [`MS_DATA_W-1:0] resp_rdata,
   input  logic                  resp_hit,
   input  logic [`MS_DATA_W-1:0] exp_rdata,
   input  logic                  exp_hit,
   output int                    resp_count,
   output int                    data_errs,
   output int                    hit_errs,
   output int                    lat_errs,
   output int                    proto_errs
);

   localparam int LINES   = 2 ** `MS_INDEX_W;
   // Lowest index bit sits above the word and byte bits
   localparam int INDEX_LO = 1 + $clog2(`MS_WORDS_PER_LINE);
   // Shortest clean miss covers lookup, four read issues, bank latency and response
   localparam int MISS_MIN_LAT = 2 + `MS_WORDS_PER_LINE + `MS_BANK_LATENCY;

   ////////////////////////////////////////////////////////////////////////////
   // Direct-mapped reference model
   ////////////////////////////////////////////////////////////////////////////
   logic [`MS_TAG_W-1:0]  tag_m   [LINES];
   logic                  valid_m [LINES];
   logic                  dirty_m [LINES];
   // Flat CPU view of memory with one entry per 16-bit word
   logic [`MS_DATA_W-1:0] word_m  [2**(`MS_ADDR_W-1)];

   // Outstanding requests with the oldest first
   logic [`MS_DATA_W-1:0] model_rdata_q [$];
   logic                  model_hit_q   [$];
   logic                  evict_q       [$];
   logic [`MS_DATA_W-1:0] file_rdata_q  [$];
   logic                  file_hit_q    [$];
   int                    accept_cyc_q  [$];

   int   resp_cnt_r   = 0;
   int   data_err_r   = 0;
   int   hit_err_r    = 0;
   int   lat_err_r    = 0;
   int   proto_err_r  = 0;
   int   cycle        = 0;
   logic reset_seen   = 1'b0;

   assign resp_count = resp_cnt_r;
   assign data_errs  = data_err_r;
   assign hit_errs   = hit_err_r;
   assign lat_errs   = lat_err_r;
   assign proto_errs = proto_err_r;

   // Rising edges seen so far
   always @(posedge clk) begin
      cycle++;
   end

   always @(negedge clk) begin : watch
      logic [`MS_TAG_W-1:0]   tag;
      logic [`MS_INDEX_W-1:0] idx;
      logic [`MS_ADDR_W-2:0]  widx;
      logic                   m_hit;
      logic                   m_evict;
      logic [`MS_DATA_W-1:0]  m_rdata;
      logic                   f_hit;
      logic [`MS_DATA_W-1:0]  f_rdata;
      int                     lat;
      int                     min_lat;
      if (!rst_n) begin
         for (int i = 0; i < LINES; i++) begin
            valid_m[i] = 1'b0;
         end
         reset_seen = 1'b1;
      end else begin
         // First settled cycle out of reset
         if (reset_seen) begin
            reset_seen = 1'b0;
            if (req_ready !== 1'b1 || resp_valid !== 1'b0) begin
               $display("Fail %0t ns: after reset req_ready=%b resp_valid=%b, expected 1 and 0",
                        $time, req_ready, resp_valid);
               proto_err_r++;
            end
         end
         // Ready only with nothing in flight, so it returns after the response
         if (req_ready !== (model_hit_q.size() == 0)) begin
            $display("Fail %0t ns: req_ready %b with %0d requests outstanding",
                     $time, req_ready, model_hit_q.size());
            proto_err_r++;
         end
         ////////////////////////////////////////////////////////////////////////////
         // Response side
         ////////////////////////////////////////////////////////////////////////////
         if (resp_valid) begin
            if (model_hit_q.size() == 0) begin
               $display("Response at %0t ns arrived with no request outstanding", $time);
               proto_err_r++;
            end else begin
               m_hit   = model_hit_q.pop_front();
               m_evict = evict_q.pop_front();
               m_rdata = model_rdata_q.pop_front();
               f_hit   = file_hit_q.pop_front();
               f_rdata = file_rdata_q.pop_front();
               lat     = cycle - accept_cyc_q.pop_front();
               resp_cnt_r++;
               if (resp_hit !== m_hit || resp_hit !== f_hit) begin
                  $display("Fail %0t ns: resp_hit %b, model %b, file %b",
                           $time, resp_hit, m_hit, f_hit);
                  hit_err_r++;
               end
               if (resp_rdata !== m_rdata || resp_rdata !== f_rdata) begin
                  $display("Fail %0t ns: resp_rdata 0x%h, model 0x%h, file 0x%h",
                           $time, resp_rdata, m_rdata, f_rdata);
                  data_err_r++;
               end
               // Hit path is fixed at two cycles from the accept edge
               if (m_hit) begin
                  if (lat != 2) begin
                     $display("Fail %0t ns: hit response after %0d cycles, expected 2",
                              $time, lat);
                     lat_err_r++;
                  end
               end else begin
                  // Write-back issues four more words ahead of the refill
                  min_lat = MISS_MIN_LAT + (m_evict ? `MS_WORDS_PER_LINE : 0);
                  if (lat < min_lat) begin
                     $display("Fail %0t ns: miss response after %0d cycles, expected at least %0d",
                              $time, lat, min_lat);
                     lat_err_r++;
                  end
               end
            end
         end
         ////////////////////////////////////////////////////////////////////////////
         // Request side for the coming rising edge
         ////////////////////////////////////////////////////////////////////////////
         if (req_valid && req_ready) begin
            tag   = req_addr[`MS_ADDR_W-1 -: `MS_TAG_W];
            idx   = req_addr[INDEX_LO +: `MS_INDEX_W];
            widx  = req_addr[`MS_ADDR_W-1:1];
            m_hit = valid_m[idx] && (tag_m[idx] == tag);
            // A miss on a dirty line writes it back first
            m_evict = !m_hit && valid_m[idx] && dirty_m[idx];
            // Allocate on every miss since write-back is invisible at the CPU port
            if (!m_hit) begin
               tag_m[idx]   = tag;
               valid_m[idx] = 1'b1;
               dirty_m[idx] = 1'b0;
            end
            m_rdata = '0;
            if (req_op == op_write) begin
               word_m[widx] = req_wdata;
               dirty_m[idx] = 1'b1;
            end else begin
               m_rdata = word_m[widx];
            end
            model_hit_q.push_back(m_hit);
            evict_q.push_back(m_evict);
            model_rdata_q.push_back(m_rdata);
            file_hit_q.push_back(exp_hit);
            file_rdata_q.push_back(exp_rdata);
            accept_cyc_q.push_back(cycle);
         end
      end
   end

endmodule

// ==== dv/mem_system_stimulus.txt ====
# op addr wdata exp_rdata exp_hit gap  (op 0 read, 1 write; hex except gap)
# gap is idle cycles after the accept, -1 for a random 0 to 3 cycle gap
1 0008 1111 0000 0  0
0 0008 0000 1111 1  0
0 0008 0000 1111 1  3
1 0010 a0a0 0000 0  1
1 0012 a1a1 0000 1  0
1 0014 a2a2 0000 1  0
1 0016 a3a3 0000 1  2
1 0810 b0b0 0000 0  0
0 0014 0000 a2a2 0  0
0 0010 0000 a0a0 1  0
0 0012 0000 a1a1 1  0
0 0016 0000 a3a3 1  1
0 0810 0000 b0b0 0  2
1 0080 c0c0 0000 0 -1
1 0082 c1c1 0000 1 -1
0 0080 0000 c0c0 1 -1
1 1080 d0d0 0000 0 -1
0 0082 0000 c1c1 0 -1
0 1080 0000 d0d0 0 -1
1 1086 d3d3 0000 1 -1
0 1086 0000 d3d3 1 -1
1 1880 e0e0 0000 0 -1
0 1880 0000 e0e0 1 -1
0 0080 0000 c0c0 0 -1
0 0082 0000 c1c1 1 -1
1 fff8 f0f0 0000 0 -1
0 fff8 0000 f0f0 1 -1
0 0008 0000 1111 1 -1
1 0008 2222 0000 1 -1
0 0008 0000 2222 1 -1
1 0808 3333 0000 0 -1
0 0008 0000 2222 0 -1
0 0808 0000 3333 0 -1

// ==== dv/tb_mem_system.sv ====
// Run from the project root so the stimulus path resolves; requests are issued in file order
`timescale 1ns/10ps
`include "mem_system_defines.svh"

module tb_mem_system
   import cache_pkg::*;
();

   localparam string STIM_PATH = "dv/mem_system_stimulus.txt";
   localparam int    ADDR_W    = `MS_ADDR_W;
   localparam int    DATA_W    = `MS_DATA_W;

   logic                  clk;
   logic                  rst_n;
   logic                  req_valid;
   cpu_op_t               req_op;
   logic [`MS_ADDR_W-1:0] req_addr;
   logic [`MS_DATA_W-1:0] req_wdata;
   logic                  req_ready;
   logic                  resp_valid;
   logic [`MS_DATA_W-1:0] resp_rdata;
   logic                  resp_hit;
   // Expected fields, travel with the request
   logic [`MS_DATA_W-1:0] exp_rdata;
   logic                  exp_hit;

   int resp_count;
   int data_errs;
   int hit_errs;
   int lat_errs;
   int proto_errs;

   // Stimulus table, one entry per file line
   int op_list    [$];
   int addr_list  [$];
   int wdata_list [$];
   int rdata_list [$];
   int hit_list   [$];
   int gap_list   [$];

   int          n_req       = 0;
   int          load_errs   = 0;
   int          cycle_cnt   = 0;
   int          cycle_limit = 100;
   logic [15:0] lfsr_state;

   mem_system DUT (
      .clk        (clk),
      .rst_n      (rst_n),
      .req_valid  (req_valid),
      .req_op     (req_op),
      .req_addr   (req_addr),
      .req_wdata  (req_wdata),
      .req_ready  (req_ready),
      .resp_valid (resp_valid),
      .resp_rdata (resp_rdata),
      .resp_hit   (resp_hit)
   );

   mem_system_checker u_checker (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Run limit from the request count
   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= cycle_limit) begin
         $display("Simulation timed out after %0d cycles, %0d of %0d responses seen",
                  cycle_cnt, resp_count, n_req);
         $display("Test failed");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////
   // x^16 + x^14 + x^13 + x^11 + 1, new bit enters at bit 0
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic draw_random_gap(output int gap);
      gap = 0;
      for (int b = 0; b < 2; b++) begin
         lfsr_state = lfsr_step(lfsr_state);
         gap = gap * 2;
         if (lfsr_state[0])
            gap = gap + 1;
      end
   endtask

   task automatic load_stimulus();
      int    fd;
      int    f_op;
      int    f_addr;
      int    f_wdata;
      int    f_rdata;
      int    f_hit;
      int    f_gap;
      string line;
      fd = $fopen(STIM_PATH, "r");
      if (fd == 0) begin
         $display("Could not open stimulus file %s", STIM_PATH);
         load_errs++;
      end else begin
         while ($fgets(line, fd) != 0) begin
            // Column notes start with a hash
            if (line.getc(0) != "#" &&
                $sscanf(line, "%h %h %h %h %h %d",
                        f_op, f_addr, f_wdata, f_rdata, f_hit, f_gap) == 6) begin
               op_list.push_back(f_op);
               addr_list.push_back(f_addr);
               wdata_list.push_back(f_wdata);
               rdata_list.push_back(f_rdata);
               hit_list.push_back(f_hit);
               gap_list.push_back(f_gap);
            end
         end
         $fclose(fd);
         if (op_list.size() == 0) begin
            $display("Stimulus file %s holds no requests", STIM_PATH);
            load_errs++;
         end
      end
   endtask

   // Holds the request until accepted, returns 1 ns after the accept edge
   task automatic send_request(input int i);
      logic ready_seen;
      req_valid = 1'b1;
      req_op    = (op_list[i] != 0) ? op_write : op_read;
      req_addr  = ADDR_W'(addr_list[i]);
      req_wdata = DATA_W'(wdata_list[i]);
      exp_rdata = DATA_W'(rdata_list[i]);
      exp_hit   = (hit_list[i] != 0);
      ready_seen = 1'b0;
      while (!ready_seen) begin
         @(negedge clk);
         ready_seen = req_ready;
         @(posedge clk);
      end
      #1;
      req_valid = 1'b0;
      req_op    = op_read;
      req_addr  = '0;
      req_wdata = '0;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      int gap;
      rst_n      = 1'b0;
      req_valid  = 1'b0;
      req_op     = op_read;
      req_addr   = '0;
      req_wdata  = '0;
      exp_rdata  = '0;
      exp_hit    = 1'b0;
      lfsr_state = 16'd36047;
      load_stimulus();
      n_req       = op_list.size();
      cycle_limit = 200 * n_req + 100;
      repeat (5) @(posedge clk);
      #1;
      rst_n = 1'b1;
      for (int i = 0; i < n_req; i++) begin
         send_request(i);
         if (gap_list[i] < 0)
            draw_random_gap(gap);
         else
            gap = gap_list[i];
         idle_cycles(gap);
      end
      // Drain outstanding responses
      while (resp_count < n_req) begin
         @(posedge clk);
      end
      repeat (4) @(posedge clk);
      $display("Errors: data %0d, hit %0d, latency %0d, protocol %0d, stimulus %0d",
               data_errs, hit_errs, lat_errs, proto_errs, load_errs);
      if (data_errs + hit_errs + lat_errs + proto_errs + load_errs == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the memory system testbench with Verilator from the project root
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --top-module tb_mem_system -f build.f -o sim_mem_system

./obj_dir/sim_mem_system > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
   echo "Simulation FAILED"
   exit 1
fi

echo "Simulation PASSED"
exit 0

// ==== source/bank_dispatch.sv ====
// Steers a memory request to one bank by its word-in-line bits; adds no cycles
`timescale 1ns/10ps
`include "mem_system_defines.svh"

module bank_dispatch
   import mem_pkg::*;
(
   input  logic                        mreq_valid,
   input  bank_op_t                    mreq_op,
   input  logic [`MS_ADDR_W-1:0]       mreq_addr,
   input  logic [`MS_DATA_W-1:0]       mreq_wdata,
   output logic                        mreq_ready,
   output logic [NUM_BANKS-1:0]        bank_valid,
   output bank_op_t                    bank_op    [NUM_BANKS],
   output logic [`MS_BANK_DEPTH_W-1:0] bank_waddr [NUM_BANKS],
   output logic [`MS_DATA_W-1:0]       bank_wdata [NUM_BANKS],
   input  logic [NUM_BANKS-1:0]        bank_ready
);

   localparam int SEL_W = $clog2(NUM_BANKS);

   logic [SEL_W-1:0] sel;

   // Address bits 2..1, byte bit 0 dropped
   assign sel        = mreq_addr[1 +: SEL_W];
   assign mreq_ready = bank_ready[sel];

   always_comb begin
      for (int b = 0; b < NUM_BANKS; b++) begin
         // Valid only to the selected bank
         bank_valid[b] = mreq_valid && (sel == SEL_W'(b));
         bank_op[b]    = mreq_op;
         // Tag and index form the word address inside a bank
         bank_waddr[b] = mreq_addr[`MS_ADDR_W-1 -: `MS_BANK_DEPTH_W];
         bank_wdata[b] = mreq_wdata;
      end
   end

endmodule

// ==== source/bank_merge.sv ====
// Fixed priority, lowest bank first; the winner is acknowledged in the same cycle
`timescale 1ns/10ps
`include "mem_system_defines.svh"

module bank_merge
   import mem_pkg::*;
(
   input  logic [NUM_BANKS-1:0]         rd_done,
   input  logic [`MS_DATA_W-1:0]        rd_data [NUM_BANKS],
   output logic [NUM_BANKS-1:0]         rd_taken,
   output logic                         fill_valid,
   output logic [$clog2(NUM_BANKS)-1:0] fill_slot,
   output logic [`MS_DATA_W-1:0]        fill_data
);

   localparam int SEL_W = $clog2(NUM_BANKS);

   // Scan downwards so the lowest done bank wins
   always_comb begin
      fill_slot = '0;
      for (int b = NUM_BANKS - 1; b >= 0; b--) begin
         if (rd_done[b])
            fill_slot = SEL_W'(b);
      end
   end

   assign fill_valid = |rd_done;
   assign fill_data  = rd_data[fill_slot];
   // Losers keep their done until picked
   assign rd_taken   = fill_valid ? (NUM_BANKS'(1) << fill_slot) : '0;

endmodule

// ==== source/cache_array.sv ====
// Direct-mapped line storage with combinational read; only the valid bits come out of reset defined
`timescale 1ns/10ps
`include "mem_system_defines.svh"

module cache_array (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  logic [`MS_INDEX_W-1:0]                arr_index,
   input  logic [$clog2(`MS_WORDS_PER_LINE)-1:0] arr_word,
   input  logic [`MS_DATA_W-1:0]                 arr_wdata,
   input  logic                                  arr_we,
   input  logic                                  arr_tag_we,
   input  logic [`MS_TAG_W-1:0]                  arr_new_tag,
   input  logic                                  arr_set_dirty,
   output logic [`MS_DATA_W-1:0]                 arr_rdata,
   output logic [`MS_TAG_W-1:0]                  arr_tag,
   output logic                                  arr_valid,
   output logic                                  arr_dirty
);

   localparam int LINES  = 2 ** `MS_INDEX_W;
   localparam int WORD_W = $clog2(`MS_WORDS_PER_LINE);

   // Data words, flat by index then word
   logic [`MS_DATA_W-1:0]         data_mem  [LINES*`MS_WORDS_PER_LINE];
   logic [`MS_TAG_W-1:0]          tag_mem   [LINES];
   logic                          dirty_mem [LINES];
   logic [LINES-1:0]              valid_q;
   logic [`MS_INDEX_W+WORD_W-1:0] word_addr;

   assign word_addr = {arr_index, arr_word};

   // Lookup for the presented index and word
   assign arr_rdata = data_mem[word_addr];
   assign arr_tag   = tag_mem[arr_index];
   assign arr_valid = valid_q[arr_index];
   assign arr_dirty = dirty_mem[arr_index];

   always_ff @(posedge clk) begin
      if (arr_we) begin
         data_mem[word_addr] <= arr_wdata;
      end
      if (arr_tag_we) begin
         tag_mem[arr_index] <= arr_new_tag;
      end
      // New tag means a freshly filled, clean line
      if (arr_tag_we) begin
         dirty_mem[arr_index] <= 1'b0;
      end else if (arr_we && arr_set_dirty) begin
         dirty_mem[arr_index] <= 1'b1;
      end
   end

   // Valid set once per line on its first refill
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= '0;
      end else if (arr_tag_we) begin
         valid_q[arr_index] <= 1'b1;
      end
   end

endmodule

// ==== source/cache_ctrl.sv ====
// One request in flight; a dirty victim is fully written back before any refill read is issued
`timescale 1ns/10ps
`include "mem_system_defines.svh"

module cache_ctrl
   import cache_pkg::*;
   import mem_pkg::*;
(
   input  logic                                  clk,
   input  logic                                  rst_n,
   // CPU port
   input  logic                                  req_valid,
   input  cpu_op_t                               req_op,
   input  logic [`MS_ADDR_W-1:0]                 req_addr,
   input  logic [`MS_DATA_W-1:0]                 req_wdata,
   output logic                                  req_ready,
   output logic                                  resp_valid,
   output logic [`MS_DATA_W-1:0]                 resp_rdata,
   output logic                                  resp_hit,
   // Memory request
   output logic                                  mreq_valid,
   output bank_op_t                              mreq_op,
   output logic [`MS_ADDR_W-1:0]                 mreq_addr,
   output logic [`MS_DATA_W-1:0]                 mreq_wdata,
   input  logic                                  mreq_ready,
   // Memory read return
   input  logic                                  fill_valid,
   input  logic [$clog2(`MS_WORDS_PER_LINE)-1:0] fill_slot,
   input  logic [`MS_DATA_W-1:0]                 fill_data,
   // Cache array
   output logic [`MS_INDEX_W-1:0]                arr_index,
   output logic [$clog2(`MS_WORDS_PER_LINE)-1:0] arr_word,
   output logic [`MS_DATA_W-1:0]                 arr_wdata,
   output logic                                  arr_we,
   output logic                                  arr_tag_we,
   output logic [`MS_TAG_W-1:0]                  arr_new_tag,
   output logic                                  arr_set_dirty,
   input  logic [`MS_DATA_W-1:0]                 arr_rdata,
   input  logic [`MS_TAG_W-1:0]                  arr_tag,
   input  logic                                  arr_valid,
   input  logic                                  arr_dirty
);

   localparam int WORD_W = $clog2(`MS_WORDS_PER_LINE);

   ctrl_state_t state_q;
   ctrl_state_t state_d;

   // Captured request
   cpu_op_t                op_q;
   logic [`MS_TAG_W-1:0]   tag_q;
   logic [`MS_INDEX_W-1:0] index_q;
   logic [WORD_W-1:0]      word_q;
   logic [`MS_DATA_W-1:0]  wdata_q;
   logic [`MS_DATA_W-1:0]  rdata_q;

   // Line walk, shared by write-back and refill
   logic [WORD_W-1:0]      issue_cnt_q;
   logic                   issue_done_q;
   logic [WORD_W-1:0]      fill_cnt_q;

   logic                   hit;
   logic                   last_fill;
   logic                   mreq_fire;

   assign hit       = arr_valid && (arr_tag == tag_q);
   assign last_fill = fill_valid && (fill_cnt_q == WORD_W'(`MS_WORDS_PER_LINE - 1));
   assign mreq_fire = mreq_valid && mreq_ready;
   assign req_ready = (state_q == st_idle);

   ////////////////////////////////////////////////////////////////////////////
   // Next state
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      state_d = state_q;
      case (state_q)
         st_idle:
            if (req_valid)
               state_d = st_lookup;
         st_lookup:
            if (hit)
               state_d = st_hit_resp;
            else if (arr_valid && arr_dirty)
               state_d = st_evict;
            else
               state_d = st_refill;
         // Last victim word accepted
         st_evict:
            if (mreq_fire && issue_cnt_q == '1)
               state_d = st_refill;
         st_refill:
            if (last_fill)
               state_d = st_finish;
         st_finish:
            state_d = st_miss_resp;
         default:
            state_d = st_idle;
      endcase
   end

   // Memory requests, victim under the tag still in the array
   always_comb begin
      mreq_valid = 1'b0;
      mreq_op    = bank_read;
      mreq_addr  = {tag_q, index_q, issue_cnt_q, 1'b0};
      mreq_wdata = arr_rdata;
      if (state_q == st_evict) begin
         mreq_valid = 1'b1;
         mreq_op    = bank_write;
         mreq_addr  = {arr_tag, index_q, issue_cnt_q, 1'b0};
      end else if (state_q == st_refill) begin
         mreq_valid = !issue_done_q;
      end
   end

   // Array access per state
   always_comb begin
      arr_index     = index_q;
      arr_word      = word_q;
      arr_wdata     = wdata_q;
      arr_we        = 1'b0;
      arr_tag_we    = 1'b0;
      arr_new_tag   = tag_q;
      arr_set_dirty = 1'b0;
      case (state_q)
         st_evict:
            arr_word = issue_cnt_q;
         // Fills land in their own slot, tag with the last
         st_refill: begin
            arr_word   = fill_slot;
            arr_wdata  = fill_data;
            arr_we     = fill_valid;
            arr_tag_we = last_fill;
         end
         // Pending CPU write marks the line dirty
         st_hit_resp, st_finish: begin
            arr_we        = (op_q == op_write);
            arr_set_dirty = 1'b1;
         end
         default: begin
            arr_we = 1'b0;
         end
      endcase
   end

   // Response, read data zero for writes
   always_comb begin
      resp_valid = (state_q == st_hit_resp) || (state_q == st_miss_resp);
      resp_hit   = (state_q == st_hit_resp);
      resp_rdata = '0;
      if (resp_valid && op_q == op_read)
         resp_rdata = resp_hit ? arr_rdata : rdata_q;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Registers
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q      <= st_idle;
         issue_cnt_q  <= '0;
         issue_done_q <= 1'b0;
         fill_cnt_q   <= '0;
      end else begin
         state_q <= state_d;
         if (state_q == st_lookup) begin
            issue_cnt_q  <= '0;
            issue_done_q <= 1'b0;
            fill_cnt_q   <= '0;
         end
         // Counter wraps to zero between write-back and refill
         if (mreq_fire) begin
            issue_cnt_q <= issue_cnt_q + 1'b1;
            if (state_q == st_refill && issue_cnt_q == '1)
               issue_done_q <= 1'b1;
         end
         if (state_q == st_refill && fill_valid)
            fill_cnt_q <= fill_cnt_q + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (req_valid && req_ready) begin
         op_q    <= req_op;
         tag_q   <= req_addr[`MS_ADDR_W-1 -: `MS_TAG_W];
         index_q <= req_addr[WORD_W+1 +: `MS_INDEX_W];
         word_q  <= req_addr[1 +: WORD_W];
         wdata_q <= req_wdata;
      end
      // Requested word once the line is in place
      if (state_q == st_finish)
         rdata_q <= arr_rdata;
   end

endmodule

// ==== source/cache_pkg.sv ====
// CPU opcode and cache controller state types; state encodings carry no meaning outside the controller
`include "mem_system_defines.svh"

package cache_pkg;

   // CPU request opcode
   typedef enum logic {
      op_read  = 1'b0,
      op_write = 1'b1
   } cpu_op_t;

   // Controller states
   typedef enum logic [2:0] {
      st_idle,
      // Tag compare on the captured request
      st_lookup,
      st_hit_resp,
      // Dirty victim back to memory
      st_evict,
      // Line reads and fills
      st_refill,
      st_finish,
      st_miss_resp
   } ctrl_state_t;

endpackage

// ==== source/mem_bank.sv ====
// One request in service at a time; a read result is held until taken and blocks new requests
`timescale 1ns/10ps
`include "mem_system_defines.svh"

module mem_bank
   import mem_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        bank_valid,
   input  bank_op_t                    bank_op,
   input  logic [`MS_BANK_DEPTH_W-1:0] bank_waddr,
   input  logic [`MS_DATA_W-1:0]       bank_wdata,
   output logic                        bank_ready,
   output logic [`MS_DATA_W-1:0]       rd_data,
   output logic                        rd_done,
   input  logic                        rd_taken
);

   localparam int CNT_W = $clog2(`MS_BANK_LATENCY + 1);

   logic [`MS_DATA_W-1:0] mem [2**`MS_BANK_DEPTH_W];
   logic                  busy_q;
   logic                  is_read_q;
   logic [CNT_W-1:0]      lat_q;
   logic                  accept;

   assign bank_ready = !busy_q && !rd_done;
   assign accept     = bank_valid && bank_ready;

   // Latency countdown, done after MS_BANK_LATENCY edges
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy_q    <= 1'b0;
         is_read_q <= 1'b0;
         lat_q     <= '0;
         rd_done   <= 1'b0;
      end else begin
         if (accept) begin
            busy_q    <= 1'b1;
            is_read_q <= (bank_op == bank_read);
            lat_q     <= CNT_W'(`MS_BANK_LATENCY - 1);
         end else if (busy_q) begin
            if (lat_q == '0) begin
               busy_q  <= 1'b0;
               // Writes retire with no return
               rd_done <= is_read_q;
            end else begin
               lat_q <= lat_q - 1'b1;
            end
         end
         if (rd_done && rd_taken)
            rd_done <= 1'b0;
      end
   end

   // Storage access at accept
   always_ff @(posedge clk) begin
      if (accept) begin
         if (bank_op == bank_write)
            mem[bank_waddr] <= bank_wdata;
         else
            rd_data <= mem[bank_waddr];
      end
   end

endmodule

// ==== source/mem_pkg.sv ====
// Main memory types; the bank count follows the line width so one line spans every bank once
`include "mem_system_defines.svh"

package mem_pkg;

   // Bank operation
   typedef enum logic {
      bank_read  = 1'b0,
      bank_write = 1'b1
   } bank_op_t;

   // One bank per word slot of a line
   localparam int NUM_BANKS = `MS_WORDS_PER_LINE;

endpackage

// ==== source/mem_system.sv ====
// Cache plus four-bank memory; the CPU must take every response since there is no response ready
`timescale 1ns/10ps
`include "mem_system_defines.svh"

module mem_system
   import cache_pkg::*;
   import mem_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  req_valid,
   input  cpu_op_t               req_op,
   input  logic [`MS_ADDR_W-1:0] req_addr,
   input  logic [`MS_DATA_W-1:0] req_wdata,
   output logic                  req_ready,
   output logic                  resp_valid,
   output logic [`MS_DATA_W-1:0] resp_rdata,
   output logic                  resp_hit
);

   localparam int WORD_W = $clog2(`MS_WORDS_PER_LINE);

   // Controller to memory
   logic                        mreq_valid;
   bank_op_t                    mreq_op;
   logic [`MS_ADDR_W-1:0]       mreq_addr;
   logic [`MS_DATA_W-1:0]       mreq_wdata;
   logic                        mreq_ready;
   logic                        fill_valid;
   logic [WORD_W-1:0]           fill_slot;
   logic [`MS_DATA_W-1:0]       fill_data;

   // Per bank
   logic [NUM_BANKS-1:0]        bank_valid;
   logic [NUM_BANKS-1:0]        bank_ready;
   bank_op_t                    bank_op    [NUM_BANKS];
   logic [`MS_BANK_DEPTH_W-1:0] bank_waddr [NUM_BANKS];
   logic [`MS_DATA_W-1:0]       bank_wdata [NUM_BANKS];
   logic [NUM_BANKS-1:0]        rd_done;
   logic [NUM_BANKS-1:0]        rd_taken;
   logic [`MS_DATA_W-1:0]       rd_data    [NUM_BANKS];

   // Controller to array
   logic [`MS_INDEX_W-1:0]      arr_index;
   logic [WORD_W-1:0]           arr_word;
   logic [`MS_DATA_W-1:0]       arr_wdata;
   logic                        arr_we;
   logic                        arr_tag_we;
   logic [`MS_TAG_W-1:0]        arr_new_tag;
   logic                        arr_set_dirty;
   logic [`MS_DATA_W-1:0]       arr_rdata;
   logic [`MS_TAG_W-1:0]        arr_tag;
   logic                        arr_valid;
   logic                        arr_dirty;

   ////////////////////////////////////////////////////////////////////////////
   // Cache side
   ////////////////////////////////////////////////////////////////////////////
   cache_ctrl u_ctrl (.*);

   cache_array u_array (.*);

   ////////////////////////////////////////////////////////////////////////////
   // Memory side
   ////////////////////////////////////////////////////////////////////////////
   bank_dispatch u_dispatch (.*);

   for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
      mem_bank u_bank (
         .clk        (clk),
         .rst_n      (rst_n),
         .bank_valid (bank_valid[b]),
         .bank_op    (bank_op[b]),
         .bank_waddr (bank_waddr[b]),
         .bank_wdata (bank_wdata[b]),
         .bank_ready (bank_ready[b]),
         .rd_data    (rd_data[b]),
         .rd_done    (rd_done[b]),
         .rd_taken   (rd_taken[b])
      );
   end

   bank_merge u_merge (.*);

endmodule

// ==== source/mem_system_defines.svh ====
// Widths and geometry for the whole memory system; the tag, index and word fields must sum to the address width
`ifndef MEM_SYSTEM_DEFINES_SVH
`define MEM_SYSTEM_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Address and data
////////////////////////////////////////////////////////////////////////////
`define MS_ADDR_W 16
`define MS_DATA_W 16

// Byte address split, bit 0 unused
`define MS_TAG_W 5
`define MS_INDEX_W 8
`define MS_WORDS_PER_LINE 4

////////////////////////////////////////////////////////////////////////////
// Main memory banks
////////////////////////////////////////////////////////////////////////////
// Accept to completion, in cycles
`define MS_BANK_LATENCY 3
// Word address inside one bank
`define MS_BANK_DEPTH_W 13

`endif
